//--- src/br_pkg.sv
/* branch unit package
   widths, bytecode values, return stack operations and the shared type aliases */
package br_pkg;

    localparam int dsz      = 32;          // data word width
    localparam int asz      = 17;          // instruction address width, 128K
    localparam int rs_depth = 32;          // return stack entries
    localparam int rp_w     = 5;           // return stack pointer width

    typedef logic [dsz-1:0]  data_t;       // data word
    typedef logic [asz-1:0]  addr_t;       // instruction address
    typedef logic [7:0]      byte_t;       // memory data byte
    typedef logic [2:0]      phase_t;      // decoder phase count
    typedef logic [rp_w-1:0] rp_t;         // return stack pointer

    // bytecodes seen by this unit, java values plus the eforth extensions
    typedef enum logic [7:0] {
        iload         = 8'h15,
        iload_0       = 8'h1a,
        iload_1       = 8'h1b,
        iload_2       = 8'h1c,
        iload_3       = 8'h1d,
        istore_0      = 8'h3b,
        ifeq          = 8'h99,
        ifne          = 8'h9a,
        iflt          = 8'h9b,
        ifge          = 8'h9c,
        ifgt          = 8'h9d,
        ifle          = 8'h9e,
        goto          = 8'ha7,
        jsr           = 8'ha8,
        ret           = 8'ha9,
        jreturn       = 8'hb1,     // java return
        invokevirtual = 8'hb6,
        donext        = 8'hca,     // eforth loop end
        dupr          = 8'hcb,     // copy rs top to tos
        popr          = 8'hcc,     // move rs top to tos
        pushr         = 8'hcd      // move tos to rs
    } opcode_t;

    // return stack operation, chosen by the commit stage
    typedef enum logic [1:0] {
        s_nop  = 2'd0,
        s_push = 2'd1,
        s_pop  = 2'd2,
        s_move = 2'd3              // rewrite top in place
    } stack_op_t;

    // return address of a call, pc plus the two operand bytes
    function automatic data_t ret_addr(addr_t p);
        data_t w;
        w = data_t'(p);            // zero extend
        return w + data_t'(2);
    endfunction

endpackage : br_pkg

//--- src/br_bus_if.sv
/* decoded instruction context
   one copy from the top level, read by target builder and return stack */
interface br_bus_if
    import br_pkg::*;
();

    logic    en;          // unit active, gates all state
    opcode_t code;        // current bytecode
    phase_t  phase;       // cycle within the bytecode
    data_t   tos;         // data stack top
    byte_t   data;        // operand byte from memory
    addr_t   pc;          // current instruction pointer

    modport src (
        output en,
        output code,
        output phase,
        output tos,
        output data,
        output pc
    );

    modport sink (
        input en,
        input code,
        input phase,
        input tos,
        input data,
        input pc
    );

endinterface : br_bus_if

//--- src/br_target.sv
/* branch target builder
   collects operand bytes into addresses and evaluates the if-family conditions */
module br_target
    import br_pkg::*;
(
    input  logic          ctl,
    input  logic          rst_n,
    br_bus_if.sink        bus,
    output addr_t         tgt_addr,      // merged target
    output logic          tgt_load,      // load pc register
    output logic          tgt_jump,      // request select
    output logic          tos_push,      // data stack write request
    output data_t         tos_val        // value to write
);

    addr_t a;             // address register, holds high byte
    addr_t a_hi;          // data byte as first address byte
    addr_t a_d;           // two byte merged address
    addr_t j_d;           // jsr target from tos and data
    logic  t_z;           // tos is zero
    logic  t_neg;         // tos sign bit
    logic  uses_hi;       // opcode collects a high byte in phase 0
    logic  take;          // phase 1 jump condition holds
    logic  ph0;
    logic  ph1;
    logic  ph2;

    assign a_hi  = addr_t'(bus.data);
    assign a_d   = {a[asz-9:0], bus.data};         // shift left 8, truncate
    assign j_d   = {bus.tos[asz-9:0], bus.data};
    assign t_z   = (bus.tos == '0);
    assign t_neg = bus.tos[dsz-1];

    assign ph0 = (bus.phase == 3'd0);
    assign ph1 = (bus.phase == 3'd1);
    assign ph2 = (bus.phase == 3'd2);

    // donext gets its byte here but the jump is decided by the stack side
    assign uses_hi = bus.code inside {goto, ifeq, ifne, iflt, ifge, ifgt, ifle,
                                      invokevirtual, donext};

    always_comb begin
        case (bus.code)
            ifeq:          take = t_z;
            ifne:          take = !t_z;
            iflt:          take = t_neg;
            ifge:          take = !t_neg;
            ifgt:          take = !t_z && !t_neg;
            ifle:          take = t_z || t_neg;
            goto:          take = 1'b1;            // unconditional
            invokevirtual: take = 1'b1;            // call lands on target
            default:       take = 1'b0;
        endcase
    end

    always_comb begin
        tgt_addr = a_d;                            // phase 1 default
        tgt_load = 1'b0;
        tgt_jump = 1'b0;
        tos_push = 1'b0;
        tos_val  = ret_addr(bus.pc);               // jsr return value
        if (uses_hi && ph0) begin
            tgt_addr = a_hi;                       // pc shows partial address
            tgt_load = 1'b1;
        end
        else if (take && ph1) begin
            tgt_load = 1'b1;
            tgt_jump = 1'b1;
        end
        else if (bus.code == jsr && ph2) begin
            tgt_addr = j_d;
            tgt_load = 1'b1;
            tgt_jump = 1'b1;
            tos_push = 1'b1;                       // pc + 2 to data stack
        end
    end

    // high byte capture
    always_ff @(posedge ctl) begin
        if (!rst_n) begin
            a <= '0;
        end
        else if (bus.en && uses_hi && ph0) begin
            a <= a_hi;
        end
    end

endmodule : br_target

//--- src/ret_stack.sv
/* return stack
   entry memory with a wrapping pointer, performs the operation given by commit */
module ret_stack
    import br_pkg::*;
(
    input  logic          ctl,
    input  logic          rst_n,
    br_bus_if.sink        bus,
    input  stack_op_t     rs_op,       // operation from commit
    input  data_t         rs_wdata,    // push or move value
    output data_t         rs_top,      // current top entry
    output data_t         rs_pick,     // entry below top for iload
    output logic          loop_done    // top is zero
);

    data_t rs [rs_depth];  // entries, no reset
    rp_t   rp;             // points at the top entry
    rp_t   rp1;            // next free slot
    rp_t   off;            // iload offset below top

    assign rp1 = rp + rp_t'(1);

    // offset taken from opcode, or from the operand byte for iload
    always_comb begin
        case (bus.code)
            iload:   off = bus.data[rp_w-1:0];      // wraps with the pointer
            iload_1: off = rp_t'(1);
            iload_2: off = rp_t'(2);
            iload_3: off = rp_t'(3);
            default: off = '0;                      // iload_0 reads top
        endcase
    end

    assign rs_top    = rs[rp];
    assign rs_pick   = rs[rp - off];
    assign loop_done = (rs_top == '0);

    // pointer moves only on enabled edges
    always_ff @(posedge ctl) begin
        if (!rst_n) begin
            rp <= '0;
        end
        else if (bus.en) begin
            case (rs_op)
                s_push:  rp <= rp1;
                s_pop:   rp <= rp - rp_t'(1);
                default: rp <= rp;                  // nop and move keep rp
            endcase
        end
    end

    // entry writes, held off during reset
    always_ff @(posedge ctl) begin
        if (rst_n && bus.en) begin
            case (rs_op)
                s_push:  rs[rp1] <= rs_wdata;       // write above old top
                s_move:  rs[rp]  <= rs_wdata;       // rewrite top
                default: ;
            endcase
        end
    end

endmodule : ret_stack

//--- src/br_commit.sv
/* commit stage
   merges target and stack results, picks the stack operation, registers outputs */
module br_commit
    import br_pkg::*;
(
    input  logic          ctl,
    input  logic          rst_n,
    br_bus_if.sink        bus,
    input  addr_t         tgt_addr,
    input  logic          tgt_load,
    input  logic          tgt_jump,
    input  logic          tos_push,
    input  data_t         tos_val,
    input  data_t         rs_top,
    input  data_t         rs_pick,
    input  logic          loop_done,
    output stack_op_t     rs_op,
    output data_t         rs_wdata,
    output addr_t         pc_out,      // registered pointer
    output logic          psel,        // select strobe
    output logic          tos_we,      // data stack write strobe
    output data_t         tos_out      // data stack write value
);

    addr_t a_n;            // next pointer
    logic  ld_n;           // load pointer
    logic  sel_n;          // select next cycle
    logic  we_n;           // data stack write next cycle
    data_t t_n;            // data stack value
    addr_t r_a;            // rs top as address
    logic  ph0;

    assign r_a = rs_top[asz-1:0];
    assign ph0 = (bus.phase == 3'd0);

    always_comb begin
        a_n      = tgt_addr;               // target side by default
        ld_n     = tgt_load;
        sel_n    = tgt_jump;
        we_n     = tos_push;
        t_n      = tos_val;
        rs_op    = s_nop;
        rs_wdata = bus.tos;
        case (bus.code)
            iload, iload_0, iload_1, iload_2, iload_3: begin
                we_n = 1'b1;
                t_n  = rs_pick;            // local variable load
            end
            istore_0: rs_op = s_move;      // tos replaces top
            ret: begin
                a_n   = r_a;               // top kept
                ld_n  = 1'b1;
                sel_n = 1'b1;
            end
            jreturn: if (ph0) begin
                rs_op = s_pop;
                a_n   = r_a;               // old top is return address
                ld_n  = 1'b1;
                sel_n = 1'b1;
            end
            invokevirtual: if (ph0) begin
                rs_op    = s_push;
                rs_wdata = ret_addr(bus.pc);
            end
            donext: if (bus.phase == 3'd1) begin
                if (loop_done) begin
                    rs_op = s_pop;         // loop over, fall through
                end
                else begin
                    rs_op    = s_move;
                    rs_wdata = rs_top - data_t'(1);
                    ld_n     = 1'b1;
                    sel_n    = 1'b1;       // back to loop head
                end
            end
            dupr: begin
                we_n = 1'b1;
                t_n  = rs_top;
            end
            popr: begin
                we_n  = 1'b1;
                t_n   = rs_top;
                rs_op = s_pop;
            end
            pushr: rs_op = s_push;         // rs_wdata already tos
            default: ;
        endcase
    end

    // control outputs, strobes drop on any disabled edge
    always_ff @(posedge ctl) begin
        if (!rst_n) begin
            pc_out <= '0;
            psel   <= 1'b0;
            tos_we <= 1'b0;
        end
        else begin
            psel   <= bus.en && sel_n;
            tos_we <= bus.en && we_n;
            if (bus.en && ld_n) pc_out <= a_n;
        end
    end

    // write value, only meaningful with tos_we
    always_ff @(posedge ctl) begin
        if (bus.en && we_n) tos_out <= t_n;
    end

endmodule : br_commit

//--- src/br_unit.sv
/* branching unit top level
   plain decoder ports in, pointer and data stack write strobes out */
module br_unit
    import br_pkg::*;
(
    input  logic          ctl,
    input  logic          rst_n,
    input  logic          en,          // unit active
    input  logic [7:0]    code,        // raw bytecode
    input  logic [2:0]    phase,       // phase count
    input  data_t         tos,         // data stack top
    input  logic [7:0]    data,        // memory data byte
    input  addr_t         pc,          // current pointer
    output addr_t         pc_out,      // new pointer
    output logic          psel,        // pointer select strobe
    output logic          tos_we,      // data stack write strobe
    output data_t         tos_out      // data stack write value
);

    br_bus_if bus ();

    addr_t     tgt_addr;
    logic      tgt_load;
    logic      tgt_jump;
    logic      tos_push;
    data_t     tos_val;
    data_t     rs_top;
    data_t     rs_pick;
    logic      loop_done;
    stack_op_t rs_op;
    data_t     rs_wdata;

    // decoder context onto the shared bus
    assign bus.en    = en;
    assign bus.code  = opcode_t'(code);
    assign bus.phase = phase;
    assign bus.tos   = tos;
    assign bus.data  = data;
    assign bus.pc    = pc;

    br_target u_target (
        .ctl      (ctl),
        .rst_n    (rst_n),
        .bus      (bus),
        .tgt_addr (tgt_addr),
        .tgt_load (tgt_load),
        .tgt_jump (tgt_jump),
        .tos_push (tos_push),
        .tos_val  (tos_val)
    );

    ret_stack u_stack (
        .ctl       (ctl),
        .rst_n     (rst_n),
        .bus       (bus),
        .rs_op     (rs_op),
        .rs_wdata  (rs_wdata),
        .rs_top    (rs_top),
        .rs_pick   (rs_pick),
        .loop_done (loop_done)
    );

    br_commit u_commit (
        .ctl       (ctl),
        .rst_n     (rst_n),
        .bus       (bus),
        .tgt_addr  (tgt_addr),
        .tgt_load  (tgt_load),
        .tgt_jump  (tgt_jump),
        .tos_push  (tos_push),
        .tos_val   (tos_val),
        .rs_top    (rs_top),
        .rs_pick   (rs_pick),
        .loop_done (loop_done),
        .rs_op     (rs_op),
        .rs_wdata  (rs_wdata),
        .pc_out    (pc_out),
        .psel      (psel),
        .tos_we    (tos_we),
        .tos_out   (tos_out)
    );

endmodule : br_unit

//--- test/br_assertions.sv
/* strobe checker bound into the branching unit
   reset, enable and goto strobe properties */
module br_assertions
    import br_pkg::*;
(
    input logic       ctl,
    input logic       rst_n,
    input logic       en,
    input logic [7:0] code,
    input logic [2:0] phase,
    input logic       psel,
    input logic       tos_we
);
    timeunit 1ns;
    timeprecision 100ps;

    logic goto_ph1;                          // enabled goto low byte

    assign goto_ph1 = en && (code == goto) && (phase == 3'd1);

    a_reset_quiet: assert property (@(posedge ctl) !rst_n |=> !psel && !tos_we)
        else $error("strobe high after a reset edge");

    a_en_low_quiet: assert property (@(posedge ctl) disable iff (!rst_n)
        !en |=> !psel && !tos_we)
        else $error("strobe follows a disabled cycle");

    a_goto_strobe: assert property (@(posedge ctl) disable iff (!rst_n)
        goto_ph1 |=> psel)
        else $error("goto low byte gave no select");

    // next goto high byte is enabled but must not select
    a_goto_single: assert property (@(posedge ctl) disable iff (!rst_n)
        goto_ph1 ##1 (en && code == goto && phase == 3'd0) |=> !psel)
        else $error("goto select held two cycles");

endmodule : br_assertions

bind br_unit br_assertions chk0 (
    .ctl    (ctl),
    .rst_n  (rst_n),
    .en     (en),
    .code   (code),
    .phase  (phase),
    .psel   (psel),
    .tos_we (tos_we)
);

//--- test/br_tb.sv
/* branching unit testbench
   lcg driven bytecode phases checked against a model return stack and address register */
module br_tb
    import br_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic        ctl;
    logic        rst_n;
    logic        en;
    logic [7:0]  code;
    logic [2:0]  phase;
    data_t       tos;
    logic [7:0]  data;
    addr_t       pc;
    addr_t       pc_out;
    logic        psel;
    logic        tos_we;
    data_t       tos_out;

    data_t       m_rs [rs_depth];            // model return stack
    rp_t         m_rp;                       // model top pointer
    addr_t       m_a;                        // model high byte register
    addr_t       m_pc;                       // model pc_out
    logic        e_psel;
    logic        e_we;
    data_t       e_tos;
    logic        have_exp;                   // first prediction made
    logic        have_tos;                   // a data stack write predicted
    logic        timed_out;
    int          checks;
    int          errors;
    logic [31:0] seed;

    br_unit dut0 (
        .ctl     (ctl),
        .rst_n   (rst_n),
        .en      (en),
        .code    (code),
        .phase   (phase),
        .tos     (tos),
        .data    (data),
        .pc      (pc),
        .pc_out  (pc_out),
        .psel    (psel),
        .tos_we  (tos_we),
        .tos_out (tos_out)
    );

    initial begin
        ctl = 1'b0;
        forever #5 ctl = ~ctl;               // 10 ns period
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // if-family condition on the data stack top
    function automatic logic taken(input logic [7:0] c, input data_t t);
        logic zero;
        logic neg;
        zero = (t == '0);
        neg  = t[dsz-1];
        case (c)
            ifeq:                return zero;
            ifne:                return !zero;
            iflt:                return neg;
            ifge:                return !neg;
            ifgt:                return !zero && !neg;
            ifle:                return !(!zero && !neg);
            goto, invokevirtual: return 1'b1;
            default:             return 1'b0;
        endcase
    endfunction

    // advances the model by one sampled phase, sets the outputs expected after the edge
    function automatic void predict(input logic r, input logic e, input logic [7:0] c,
                                    input logic [2:0] ph, input data_t t,
                                    input logic [7:0] d, input addr_t p);
        addr_t merged;
        data_t top;
        rp_t   off;
        merged = {m_a[asz-9:0], d};          // high byte shifted up, truncated
        top    = m_rs[m_rp];
        e_psel = 1'b0;
        e_we   = 1'b0;
        if (!r) begin
            m_pc = '0;
            m_rp = '0;
            m_a  = '0;
        end
        else if (e) begin
            if (ph == 3'd0 && c inside {goto, ifeq, ifne, iflt, ifge, ifgt, ifle,
                                        invokevirtual, donext}) begin
                m_a  = addr_t'(d);
                m_pc = addr_t'(d);           // partial address shows on pc_out
            end
            if (ph == 3'd1 && taken(c, t)) begin
                m_pc   = merged;
                e_psel = 1'b1;
            end
            case (c)
                jsr: if (ph == 3'd2) begin
                    m_pc   = {t[asz-9:0], d};
                    e_psel = 1'b1;
                    e_we   = 1'b1;
                    e_tos  = data_t'(p) + data_t'(2);
                end
                invokevirtual: if (ph == 3'd0) begin
                    m_rp       = m_rp + rp_t'(1);
                    m_rs[m_rp] = data_t'(p) + data_t'(2);
                end
                ret: begin
                    m_pc   = top[asz-1:0];   // top stays
                    e_psel = 1'b1;
                end
                jreturn: if (ph == 3'd0) begin
                    m_pc   = top[asz-1:0];
                    e_psel = 1'b1;
                    m_rp   = m_rp - rp_t'(1);
                end
                donext: if (ph == 3'd1) begin
                    if (top == '0) begin
                        m_rp = m_rp - rp_t'(1);
                    end
                    else begin
                        m_rs[m_rp] = top - data_t'(1);
                        m_pc       = merged;
                        e_psel     = 1'b1;
                    end
                end
                iload, iload_0, iload_1, iload_2, iload_3: begin
                    off   = (c == iload) ? d[rp_w-1:0] : rp_t'(c - iload_0);
                    e_we  = 1'b1;
                    e_tos = m_rs[m_rp - off];
                end
                istore_0: m_rs[m_rp] = t;
                dupr: begin
                    e_we  = 1'b1;
                    e_tos = top;
                end
                popr: begin
                    e_we  = 1'b1;
                    e_tos = top;
                    m_rp  = m_rp - rp_t'(1);
                end
                pushr: begin
                    m_rp       = m_rp + rp_t'(1);
                    m_rs[m_rp] = t;
                end
                default: ;
            endcase
        end
    endfunction

    // one enabled phase, random pc
    task automatic issue(input logic [7:0] c, input logic [2:0] ph, input data_t t,
                         input logic [7:0] d);
        logic [31:0] r;
        r = lcg_next();
        @(posedge ctl);
        en    <= 1'b1;
        code  <= c;
        phase <= ph;
        tos   <= t;
        data  <= d;
        pc    <= r[asz-1:0];
    endtask

    // disabled cycles with random opcodes and operands
    task automatic idle_cycles(input int n);
        logic [31:0] r;
        repeat (n) begin
            r = lcg_next();
            @(posedge ctl);
            en    <= 1'b0;
            code  <= r[7:0];
            phase <= r[10:8];
            tos   <= {r[15:0], r[31:16]};
            data  <= r[23:16];
            pc    <= r[asz-1:0];
        end
    endtask

    task automatic branch_pair(input logic [7:0] op, input data_t t);
        logic [31:0] r;
        r = lcg_next();
        issue(op, 3'd0, t, r[15:8]);         // high byte
        issue(op, 3'd1, t, r[7:0]);          // low byte, jump decision
    endtask

    // compares one cycle after each sampled phase, then predicts the next
    initial begin
        forever begin
            @(negedge ctl);
            if (have_exp) begin
                checks = checks + 1;
                if (pc_out !== m_pc) begin
                    errors = errors + 1;
                    $display("ERROR %0t: pc_out %h, expected %h", $time, pc_out, m_pc);
                end
                if (psel !== e_psel) begin
                    errors = errors + 1;
                    $display("ERROR %0t: psel %b, expected %b", $time, psel, e_psel);
                end
                if (tos_we !== e_we) begin
                    errors = errors + 1;
                    $display("ERROR %0t: tos_we %b, expected %b", $time, tos_we, e_we);
                end
                if (have_tos && tos_out !== e_tos) begin    // held between writes
                    errors = errors + 1;
                    $display("ERROR %0t: tos_out %h, expected %h", $time, tos_out, e_tos);
                end
            end
            predict(rst_n, en, code, phase, tos, data, pc);
            if (e_we) have_tos = 1'b1;
            have_exp = 1'b1;
        end
    end

    initial begin
        int          i;
        int          k;
        int          n;
        int          jumps;
        logic [31:0] r;
        data_t       t;
        logic [7:0]  op;
        logic        fell;
        seed      = 32'h0861bd7f;
        have_exp  = 1'b0;
        have_tos  = 1'b0;
        timed_out = 1'b0;
        checks    = 0;
        errors    = 0;
        rst_n     = 1'b0;
        en        = 1'b0;
        code      = '0;
        phase     = '0;
        tos       = '0;
        data      = '0;
        pc        = '0;
        repeat (3) @(posedge ctl);           // reset over 3 edges
        rst_n <= 1'b1;
        idle_cycles(2);

        for (i = 0; i < 24; i++) begin       // all six if ops, random tos
            case (i % 6)
                0:       op = ifeq;
                1:       op = ifne;
                2:       op = iflt;
                3:       op = ifge;
                4:       op = ifgt;
                default: op = ifle;
            endcase
            r = lcg_next();
            t = (r[3:2] == 2'b00) ? '0 : lcg_next();   // zero often enough
            branch_pair(op, t);
            if (r[4]) idle_cycles(1);
        end

        branch_pair(goto, '0);
        branch_pair(goto, '0);               // back to back, select not held
        idle_cycles(1);                      // lone goto strobe
        branch_pair(invokevirtual, '0);      // call pushes pc + 2
        issue(ret, 3'd0, '0, 8'd0);          // jump to top, keep it
        issue(jreturn, 3'd0, '0, 8'd0);      // back to the call site
        for (i = 0; i < 3; i++) issue(jsr, 3'(i), lcg_next(), 8'h5a);
        idle_cycles(1);

        for (i = 0; i < 8; i++) issue(pushr, 3'd0, lcg_next(), 8'd0);
        for (i = 0; i < 4; i++) issue(8'(iload_0 + i), 3'd0, '0, 8'd0);
        for (i = 0; i < 4; i++) begin
            r = lcg_next();
            issue(iload, 3'd0, '0, {5'd0, r[2:0]});    // stays inside pushed entries
        end
        issue(dupr, 3'd0, '0, 8'd0);
        issue(istore_0, 3'd0, lcg_next(), 8'd0);
        issue(dupr, 3'd0, '0, 8'd0);
        for (i = 0; i < 8; i++) issue(popr, 3'd0, '0, 8'd0);

        r = lcg_next();
        n = 2 + int'(r % 5);                 // loop count
        issue(pushr, 3'd0, data_t'(n), 8'd0);
        jumps = 0;
        fell  = 1'b0;
        k     = 0;
        while (!fell && k < 40) begin
            r = lcg_next();
            issue(donext, 3'd0, '0, r[15:8]);
            issue(donext, 3'd1, '0, r[7:0]);
            idle_cycles(1);
            @(negedge ctl);
            if (psel) jumps = jumps + 1;
            else fell = 1'b1;
            k = k + 1;
        end
        if (!fell) begin
            $display("timeout: donext loop never fell through after %0d passes", k);
            timed_out = 1'b1;
        end
        else if (jumps != n) begin
            errors = errors + 1;
            $display("ERROR %0t: donext jumped %0d times, expected %0d", $time, jumps, n);
        end

        idle_cycles(20);                     // en low, random opcodes
        idle_cycles(3);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0 && !timed_out)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule : br_tb

//--- sources.f
src/br_pkg.sv
src/br_bus_if.sv
src/br_target.sv
src/ret_stack.sv
src/br_commit.sv
src/br_unit.sv
test/br_assertions.sv
test/br_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the branching unit testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module br_tb -f sources.f -o br_sim
./obj_dir/br_sim | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run.sh: failure reported in sim.log"
    exit 1
fi
echo "run.sh: no failure in sim.log"
